// File: hdl/icache_arrays.sv
`default_nettype none

module icache_arrays import icache_pkg::*; (
  input  wire logic                                         clk,
  input  wire logic                                         rst_n,
  input  wire logic [INDEX_W-1:0]                           rd_index_i,
  output logic [WAY_NUM-1:0][TAG_W-1:0]                     tag_rd_o,
  output logic [WAY_NUM-1:0]                                valid_rd_o,
  output logic [WAY_NUM-1:0][LINE_WORDS-1:0][WORD_W-1:0]    line_rd_o,
  output logic [WAY_W-1:0]                                  repl_way_o,
  input  wire logic                                         line_we_i,
  input  wire logic [WAY_W-1:0]                             line_way_i,
  input  wire logic [INDEX_W-1:0]                           line_index_i,
  input  wire logic [TAG_W-1:0]                             line_tag_i,
  input  wire logic [LINE_WORDS-1:0][WORD_W-1:0]            line_data_i,
  input  wire logic                                         hit_update_i,
  input  wire logic [WAY_W-1:0]                             hit_way_i,
  input  wire logic [WAY_NUM-1:0]                           inv_en_i,
  input  wire logic [INDEX_W-1:0]                           inv_index_i
);

  logic [TAG_W-1:0]                  tag_mem  [WAY_NUM][2**INDEX_W];
  logic [LINE_WORDS-1:0][WORD_W-1:0] data_mem [WAY_NUM][2**INDEX_W];
  logic [WAY_NUM-1:0]                valid_q  [2**INDEX_W];
  logic [WAY_W-1:0]                  repl_q   [2**INDEX_W];
  // set seen by stage 1
  logic [INDEX_W-1:0]                rd_index_q;

  // ====================
  // storage
  // ====================
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAY_NUM; w++) begin
      if (line_we_i && line_way_i == WAY_W'(w)) begin
        tag_mem[w][line_index_i]  <= line_tag_i;
        data_mem[w][line_index_i] <= line_data_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_index_q <= '0;
      for (int s = 0; s < 2**INDEX_W; s++) begin
        valid_q[s] <= '0;
        repl_q[s]  <= '0;
      end
    end else begin
      rd_index_q <= rd_index_i;
      for (int w = 0; w < WAY_NUM; w++) begin
        if (line_we_i && line_way_i == WAY_W'(w)) begin
          valid_q[line_index_i][w] <= 1'b1;
        end
        if (inv_en_i[w]) begin
          valid_q[inv_index_i][w] <= 1'b0;
        end
      end
      // next victim is the way that did not hit
      if (hit_update_i) begin
        repl_q[rd_index_q] <= ~hit_way_i;
      end
    end
  end

  // ====================
  // read port
  // ====================
  // registered index, so a write at the same edge is visible
  always_comb begin
    for (int w = 0; w < WAY_NUM; w++) begin
      tag_rd_o[w]   = tag_mem[w][rd_index_q];
      valid_rd_o[w] = valid_q[rd_index_q][w];
      line_rd_o[w]  = data_mem[w][rd_index_q];
    end
  end

  assign repl_way_o = repl_q[rd_index_q];

  // refill and maintenance are never active together
  assert property (@(posedge clk) disable iff (!rst_n) !(line_we_i && |inv_en_i))
    else $error("line write collides with invalidate");

endmodule

`default_nettype wire

// File: hdl/icache_lookup.sv
`default_nettype none

module icache_lookup import icache_pkg::*; (
  input  wire logic                                         clk,
  input  wire logic                                         rst_n,
  input  wire logic                                         fetch_valid_i,
  input  wire logic [ADDR_W-1:0]                            fetch_addr_i,
  output logic                                              fetch_ready_o,
  input  wire logic                                         cacop_valid_i,
  input  wire cacop_mode_e                                  cacop_mode_i,
  input  wire logic [ADDR_W-1:0]                            cacop_addr_i,
  output logic                                              cacop_ready_o,
  output logic                                              cacop_done_o,
  output logic                                              rsp_valid_o,
  output logic [ADDR_W-1:0]                                 rsp_addr_o,
  output logic [WORD_W-1:0]                                 rsp_instr_o,
  output logic [INDEX_W-1:0]                                rd_index_o,
  input  wire logic [WAY_NUM-1:0][TAG_W-1:0]                tag_rd_i,
  input  wire logic [WAY_NUM-1:0]                           valid_rd_i,
  input  wire logic [WAY_NUM-1:0][LINE_WORDS-1:0][WORD_W-1:0] line_rd_i,
  input  wire logic                                         refill_busy_i,
  output logic                                              miss_start_o,
  output logic [ADDR_W-1:0]                                 miss_addr_o,
  output logic                                              hit_update_o,
  output logic [WAY_W-1:0]                                  hit_way_o,
  output logic [WAY_NUM-1:0]                                inv_en_o,
  output logic [INDEX_W-1:0]                                inv_index_o
);

  logic               s1_fetch_en;
  logic               s1_cacop_en;
  cacop_mode_e        s1_mode;
  logic [ADDR_W-1:0]  s1_addr;
  logic               replay_q;
  logic [WAY_NUM-1:0] match;
  logic               hit;
  logic [WAY_W-1:0]   hit_way;
  logic               s1_hold;

  // ====================
  // stage 0
  // ====================
  // fetch waits in stage 1 on a miss, during the refill and for one replay read
  assign s1_hold = s1_fetch_en & (~hit | refill_busy_i | replay_q);

  // maintenance wins over fetch
  assign cacop_ready_o = ~s1_hold;
  assign fetch_ready_o = ~s1_hold & ~cacop_valid_i;

  always_comb begin
    if (s1_hold) begin
      // re-read the stalled set so the lookup replays
      rd_index_o = s1_addr[OFFSET_W +: INDEX_W];
    end else if (cacop_valid_i) begin
      rd_index_o = cacop_addr_i[OFFSET_W +: INDEX_W];
    end else begin
      rd_index_o = fetch_addr_i[OFFSET_W +: INDEX_W];
    end
  end

  // ====================
  // stage 1 register
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_fetch_en <= 1'b0;
      s1_cacop_en <= 1'b0;
      replay_q    <= 1'b0;
    end else begin
      // set after the refill ends, arrays hold the new line one read later
      replay_q <= refill_busy_i;
      if (!s1_hold) begin
        s1_cacop_en <= cacop_valid_i;
        s1_fetch_en <= fetch_valid_i & ~cacop_valid_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!s1_hold) begin
      s1_addr <= cacop_valid_i ? cacop_addr_i : fetch_addr_i;
      s1_mode <= cacop_mode_i;
    end
  end

  // ====================
  // tag match
  // ====================
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAY_NUM; w++) begin
      match[w] = valid_rd_i[w] && (tag_rd_i[w] == s1_addr[ADDR_W-1 -: TAG_W]);
      if (match[w]) begin
        hit_way = WAY_W'(w);
      end
    end
  end

  assign hit = |match;

  // hit response
  assign rsp_valid_o  = s1_fetch_en & hit & ~refill_busy_i & ~replay_q;
  assign rsp_addr_o   = s1_addr;
  assign rsp_instr_o  = line_rd_i[hit_way][s1_addr[2 +: BEAT_W]];
  assign hit_update_o = rsp_valid_o;
  assign hit_way_o    = hit_way;

  // miss goes to the refill engine once
  assign miss_start_o = s1_fetch_en & ~hit & ~refill_busy_i & ~replay_q;
  assign miss_addr_o  = s1_addr;

  // ====================
  // maintenance
  // ====================
  assign cacop_done_o = s1_cacop_en;
  assign inv_index_o  = s1_addr[OFFSET_W +: INDEX_W];

  always_comb begin
    inv_en_o = '0;
    if (s1_cacop_en) begin
      for (int w = 0; w < WAY_NUM; w++) begin
        if (s1_mode == CACOP_INDEX_INV) begin
          // way number comes from the low address bits
          inv_en_o[w] = (s1_addr[WAY_W-1:0] == WAY_W'(w));
        end else begin
          inv_en_o[w] = match[w];
        end
      end
    end
  end

  // every miss is taken up by the refill engine
  assert property (@(posedge clk) disable iff (!rst_n) miss_start_o |=> refill_busy_i)
    else $error("miss not taken by the refill engine");

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // ====================
  // cache geometry
  // ====================
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  // one replacement bit per set only covers two ways
  localparam int WAY_NUM    = 2;
  localparam int LINE_WORDS = 4;
  localparam int INDEX_W    = 4;

  // derived widths
  localparam int OFFSET_W = $clog2(LINE_WORDS) + 2;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_W    = $clog2(WAY_NUM);
  localparam int BEAT_W   = $clog2(LINE_WORDS);

  // ====================
  // encodings
  // ====================
  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } refill_state_e;

  typedef enum logic {
    CACOP_INDEX_INV,
    CACOP_HIT_INV
  } cacop_mode_e;

endpackage

`default_nettype wire

// File: hdl/icache_refill.sv
`default_nettype none

module icache_refill import icache_pkg::*; (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              miss_start_i,
  input  wire logic [ADDR_W-1:0]                 miss_addr_i,
  input  wire logic [WAY_W-1:0]                  repl_way_i,
  output logic                                   refill_busy_o,
  output logic                                   mem_ar_valid_o,
  output logic [ADDR_W-1:0]                      mem_ar_addr_o,
  input  wire logic                              mem_ar_ready_i,
  input  wire logic                              mem_r_valid_i,
  input  wire logic [WORD_W-1:0]                 mem_r_data_i,
  input  wire logic                              mem_r_last_i,
  output logic                                   mem_r_ready_o,
  output logic                                   line_we_o,
  output logic [WAY_W-1:0]                       line_way_o,
  output logic [INDEX_W-1:0]                     line_index_o,
  output logic [TAG_W-1:0]                       line_tag_o,
  output logic [LINE_WORDS-1:0][WORD_W-1:0]      line_data_o
);

  refill_state_e                     state;
  logic [BEAT_W-1:0]                 beat_cnt;
  logic [ADDR_W-1:0]                 miss_addr_q;
  logic [WAY_W-1:0]                  victim_q;
  logic [LINE_WORDS-1:0][WORD_W-1:0] beat_buf;
  logic                              beat_take;

  assign beat_take = (state == REFILL) && mem_r_valid_i;

  // ====================
  // miss FSM
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (miss_start_i) begin
            state <= MISS;
          end
        end
        MISS: begin
          if (mem_ar_ready_i) begin
            state <= REFILL;
          end
        end
        REFILL: begin
          if (mem_r_valid_i && mem_r_last_i) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase

      if (state != REFILL) begin
        beat_cnt <= '0;
      end else if (mem_r_valid_i) begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // miss address and victim way held for the whole refill
  always_ff @(posedge clk) begin
    if (state == IDLE && miss_start_i) begin
      miss_addr_q <= miss_addr_i;
      victim_q    <= repl_way_i;
    end
    if (beat_take) begin
      beat_buf[beat_cnt] <= mem_r_data_i;
    end
  end

  // ====================
  // memory read port
  // ====================
  assign refill_busy_o  = (state != IDLE);
  assign mem_ar_valid_o = (state == MISS);
  assign mem_ar_addr_o  = {miss_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign mem_r_ready_o  = (state == REFILL);

  // ====================
  // line write
  // ====================
  assign line_we_o    = beat_take & mem_r_last_i;
  assign line_way_o   = victim_q;
  assign line_index_o = miss_addr_q[OFFSET_W +: INDEX_W];
  assign line_tag_o   = miss_addr_q[ADDR_W-1 -: TAG_W];

  // last beat goes straight from the bus into the line
  always_comb begin
    for (int i = 0; i < LINE_WORDS; i++) begin
      line_data_o[i] = (BEAT_W'(i) == beat_cnt) ? mem_r_data_i : beat_buf[i];
    end
  end

  // a new miss only arrives once the previous refill has ended
  assert property (@(posedge clk) disable iff (!rst_n) miss_start_i |-> state == IDLE)
    else $error("miss started while a refill is running");

  assert property (@(posedge clk) disable iff (!rst_n)
    beat_take && mem_r_last_i |-> beat_cnt == BEAT_W'(LINE_WORDS - 1))
    else $error("last beat at wrong position");

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*; (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // fetch
  input  wire logic               fetch_valid_i,
  input  wire logic [ADDR_W-1:0]  fetch_addr_i,
  output logic                    fetch_ready_o,
  output logic                    rsp_valid_o,
  output logic [ADDR_W-1:0]       rsp_addr_o,
  output logic [WORD_W-1:0]       rsp_instr_o,
  // maintenance
  input  wire logic               cacop_valid_i,
  input  wire cacop_mode_e        cacop_mode_i,
  input  wire logic [ADDR_W-1:0]  cacop_addr_i,
  output logic                    cacop_ready_o,
  output logic                    cacop_done_o,
  // memory read
  output logic                    mem_ar_valid_o,
  output logic [ADDR_W-1:0]       mem_ar_addr_o,
  input  wire logic               mem_ar_ready_i,
  input  wire logic               mem_r_valid_i,
  input  wire logic [WORD_W-1:0]  mem_r_data_i,
  input  wire logic               mem_r_last_i,
  output logic                    mem_r_ready_o
);

  logic [INDEX_W-1:0]                             rd_index;
  logic [WAY_NUM-1:0][TAG_W-1:0]                  tag_rd;
  logic [WAY_NUM-1:0]                             valid_rd;
  logic [WAY_NUM-1:0][LINE_WORDS-1:0][WORD_W-1:0] line_rd;
  logic [WAY_W-1:0]                               repl_way;
  logic                                           refill_busy;
  logic                                           miss_start;
  logic [ADDR_W-1:0]                              miss_addr;
  logic                                           hit_update;
  logic [WAY_W-1:0]                               hit_way;
  logic [WAY_NUM-1:0]                             inv_en;
  logic [INDEX_W-1:0]                             inv_index;
  logic                                           line_we;
  logic [WAY_W-1:0]                               line_way;
  logic [INDEX_W-1:0]                             line_index;
  logic [TAG_W-1:0]                               line_tag;
  logic [LINE_WORDS-1:0][WORD_W-1:0]              line_data;

  icache_lookup i_icache_lookup (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .cacop_valid_i (cacop_valid_i),
    .cacop_mode_i  (cacop_mode_i),
    .cacop_addr_i  (cacop_addr_i),
    .cacop_ready_o (cacop_ready_o),
    .cacop_done_o  (cacop_done_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_addr_o    (rsp_addr_o),
    .rsp_instr_o   (rsp_instr_o),
    .rd_index_o    (rd_index),
    .tag_rd_i      (tag_rd),
    .valid_rd_i    (valid_rd),
    .line_rd_i     (line_rd),
    .refill_busy_i (refill_busy),
    .miss_start_o  (miss_start),
    .miss_addr_o   (miss_addr),
    .hit_update_o  (hit_update),
    .hit_way_o     (hit_way),
    .inv_en_o      (inv_en),
    .inv_index_o   (inv_index)
  );

  icache_arrays i_icache_arrays (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_index_i   (rd_index),
    .tag_rd_o     (tag_rd),
    .valid_rd_o   (valid_rd),
    .line_rd_o    (line_rd),
    .repl_way_o   (repl_way),
    .line_we_i    (line_we),
    .line_way_i   (line_way),
    .line_index_i (line_index),
    .line_tag_i   (line_tag),
    .line_data_i  (line_data),
    .hit_update_i (hit_update),
    .hit_way_i    (hit_way),
    .inv_en_i     (inv_en),
    .inv_index_i  (inv_index)
  );

  icache_refill i_icache_refill (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss_start_i   (miss_start),
    .miss_addr_i    (miss_addr),
    .repl_way_i     (repl_way),
    .refill_busy_o  (refill_busy),
    .mem_ar_valid_o (mem_ar_valid_o),
    .mem_ar_addr_o  (mem_ar_addr_o),
    .mem_ar_ready_i (mem_ar_ready_i),
    .mem_r_valid_i  (mem_r_valid_i),
    .mem_r_data_i   (mem_r_data_i),
    .mem_r_last_i   (mem_r_last_i),
    .mem_r_ready_o  (mem_r_ready_o),
    .line_we_o      (line_we),
    .line_way_o     (line_way),
    .line_index_o   (line_index),
    .line_tag_o     (line_tag),
    .line_data_o    (line_data)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_icache -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_icache" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: sim.f
hdl/icache_pkg.sv
hdl/icache_arrays.sv
hdl/icache_lookup.sv
hdl/icache_refill.sv
hdl/icache_top.sv
testbench/tb_mem_model.sv
testbench/tb_icache.sv

// File: testbench/tb_icache.sv
`default_nettype none

module tb_icache import icache_pkg::*; ();

  localparam logic [WORD_W-1:0] MEM_PATTERN = 32'h5a3c_96e1;
  localparam int DRIVE_DLY  = 10;
  localparam int WAIT_LIMIT = 400;
  localparam int SETS       = 2**INDEX_W;

  logic              clk;
  logic              rst_n;
  logic              fetch_valid;
  logic [ADDR_W-1:0] fetch_addr;
  logic              fetch_ready;
  logic              rsp_valid;
  logic [ADDR_W-1:0] rsp_addr;
  logic [WORD_W-1:0] rsp_instr;
  logic              cacop_valid;
  cacop_mode_e       cacop_mode;
  logic [ADDR_W-1:0] cacop_addr;
  logic              cacop_ready;
  logic              cacop_done;
  logic              mem_ar_valid;
  logic [ADDR_W-1:0] mem_ar_addr;
  logic              mem_ar_ready;
  logic              mem_r_valid;
  logic [WORD_W-1:0] mem_r_data;
  logic              mem_r_last;
  logic              mem_r_ready;

  // reference model of the tag side
  logic [TAG_W-1:0] ref_tag   [WAY_NUM][SETS];
  bit               ref_valid [WAY_NUM][SETS];
  bit               ref_repl  [SETS];

  logic [ADDR_W-1:0] stim_q[$];
  logic [ADDR_W-1:0] pend_addr_q[$];
  int                pend_cyc_q[$];
  logic [ADDR_W-1:0] last_ar_addr;
  int  cycle_cnt       = 0;
  int  read_cnt        = 0;
  int  reads_since_rsp = 0;
  int  last_beat_cyc   = 0;
  int  rsp_cnt         = 0;
  int  model_misses    = 0;
  int  cmp_errors      = 0;
  int  seq_errors      = 0;
  int  test_cnt        = 0;
  int  test_err0       = 0;
  bit  last_miss       = 1'b0;
  bit  abort_req       = 1'b0;

  icache_top i_icache_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_valid_i  (fetch_valid),
    .fetch_addr_i   (fetch_addr),
    .fetch_ready_o  (fetch_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_addr_o     (rsp_addr),
    .rsp_instr_o    (rsp_instr),
    .cacop_valid_i  (cacop_valid),
    .cacop_mode_i   (cacop_mode),
    .cacop_addr_i   (cacop_addr),
    .cacop_ready_o  (cacop_ready),
    .cacop_done_o   (cacop_done),
    .mem_ar_valid_o (mem_ar_valid),
    .mem_ar_addr_o  (mem_ar_addr),
    .mem_ar_ready_i (mem_ar_ready),
    .mem_r_valid_i  (mem_r_valid),
    .mem_r_data_i   (mem_r_data),
    .mem_r_last_i   (mem_r_last),
    .mem_r_ready_o  (mem_r_ready)
  );

  tb_mem_model i_tb_mem_model (
    .clk        (clk),
    .rst_n      (rst_n),
    .pattern_i  (MEM_PATTERN),
    .ar_valid_i (mem_ar_valid),
    .ar_addr_i  (mem_ar_addr),
    .ar_ready_o (mem_ar_ready),
    .r_valid_o  (mem_r_valid),
    .r_data_o   (mem_r_data),
    .r_last_o   (mem_r_last)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ====================
  // reference model
  // ====================
  function automatic logic [WORD_W-1:0] expected_instr(input logic [ADDR_W-1:0] a);
    return a ^ MEM_PATTERN;
  endfunction

  function automatic int model_way(input logic [ADDR_W-1:0] a);
    int way;
    way = -1;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (ref_valid[w][a[OFFSET_W +: INDEX_W]] &&
          ref_tag[w][a[OFFSET_W +: INDEX_W]] == a[ADDR_W-1 -: TAG_W]) begin
        way = w;
      end
    end
    return way;
  endfunction

  // returns 1 on a hit; a miss fills the victim way, then the replay hits
  function automatic bit model_fetch(input logic [ADDR_W-1:0] a);
    int                 way;
    bit                 hit;
    logic [INDEX_W-1:0] set;
    set = a[OFFSET_W +: INDEX_W];
    way = model_way(a);
    hit = (way >= 0);
    if (!hit) begin
      way = int'(ref_repl[set]);
      ref_tag[way][set]   = a[ADDR_W-1 -: TAG_W];
      ref_valid[way][set] = 1'b1;
    end
    // victim becomes the way that did not hit
    ref_repl[set] = (way == 0);
    return hit;
  endfunction

  function automatic void model_cacop(input cacop_mode_e mode, input logic [ADDR_W-1:0] a);
    int way;
    if (mode == CACOP_INDEX_INV) begin
      way = int'(a[WAY_W-1:0]);
    end else begin
      way = model_way(a);
    end
    if (way >= 0) begin
      ref_valid[way][a[OFFSET_W +: INDEX_W]] = 1'b0;
    end
  endfunction

  function automatic void model_reset();
    for (int s = 0; s < SETS; s++) begin
      ref_repl[s] = 1'b0;
      for (int w = 0; w < WAY_NUM; w++) begin
        ref_valid[w][s] = 1'b0;
      end
    end
  endfunction

  // ====================
  // compare process
  // ====================
  always @(negedge clk) begin : compare
    logic [ADDR_W-1:0] exp_addr;
    int                exp_cyc;
    bit                hit;
    if (!rst_n) begin
      model_reset();
    end else begin
      if (mem_ar_valid && mem_ar_ready) begin
        read_cnt++;
        reads_since_rsp++;
        last_ar_addr = mem_ar_addr;
      end
      if (mem_r_valid && !mem_r_ready) begin
        $display("memory beat at %0t was offered while the cache was not ready", $time);
        cmp_errors++;
      end
      if (mem_r_valid && mem_r_ready && mem_r_last) begin
        last_beat_cyc = cycle_cnt;
      end
      // cacop inputs still hold the operation that just completed
      if (cacop_done) begin
        model_cacop(cacop_mode, cacop_addr);
      end
      if (rsp_valid) begin
        if (pend_addr_q.size() == 0) begin
          $display("response at %0t arrived with no fetch outstanding", $time);
          cmp_errors++;
        end else begin
          exp_addr = pend_addr_q.pop_front();
          exp_cyc  = pend_cyc_q.pop_front();
          hit      = model_fetch(exp_addr);
          rsp_cnt++;
          last_miss = !hit;
          assert (rsp_addr == exp_addr)
            else begin
              $display("MISMATCH at %0t: rsp addr %h, expected %h", $time, rsp_addr, exp_addr);
              cmp_errors++;
            end
          assert (rsp_instr == expected_instr(exp_addr))
            else begin
              $display("MISMATCH at %0t: instr for %h is %h, expected %h", $time, exp_addr,
                       rsp_instr, expected_instr(exp_addr));
              cmp_errors++;
            end
          if (hit) begin
            assert (reads_since_rsp == 0 && cycle_cnt == exp_cyc)
              else begin
                $display("MISMATCH at %0t: hit on %h took %0d reads, cycle %0d, expected %0d",
                         $time, exp_addr, reads_since_rsp, cycle_cnt, exp_cyc);
                cmp_errors++;
              end
          end else begin
            model_misses++;
            assert (reads_since_rsp == 1 &&
                    last_ar_addr == (exp_addr & ~ADDR_W'(4 * LINE_WORDS - 1)))
              else begin
                $display("MISMATCH at %0t: miss on %h took %0d reads, last read addr %h",
                         $time, exp_addr, reads_since_rsp, last_ar_addr);
                cmp_errors++;
              end
            assert (cycle_cnt == last_beat_cyc + 2)
              else begin
                $display("MISMATCH at %0t: replay of %h came %0d cycles after the last beat",
                         $time, exp_addr, cycle_cnt - last_beat_cyc);
                cmp_errors++;
              end
          end
          reads_since_rsp = 0;
        end
      end
    end
  end

  // ====================
  // stimulus tasks
  // ====================
  task automatic fail_now(input string msg);
    $display("%s at %0t", msg, $time);
    abort_req = 1'b1;
    @(posedge clk);
  endtask

  // entered and left a short delay after a rising edge
  task automatic run_stream();
    logic [ADDR_W-1:0] a;
    int                wait_cyc;
    while (stim_q.size() != 0) begin
      a           = stim_q.pop_front();
      fetch_valid = 1'b1;
      fetch_addr  = a;
      wait_cyc    = 0;
      @(negedge clk);
      while (!fetch_ready) begin
        if (wait_cyc > WAIT_LIMIT) begin
          fail_now("fetch was never accepted");
        end
        wait_cyc++;
        @(negedge clk);
      end
      // accepted at the coming edge
      pend_addr_q.push_back(a);
      pend_cyc_q.push_back(cycle_cnt + 1);
      @(posedge clk);
      #DRIVE_DLY;
    end
    fetch_valid = 1'b0;
  endtask

  task automatic wait_responses();
    int wait_cyc;
    wait_cyc = 0;
    @(posedge clk);
    while (pend_addr_q.size() != 0) begin
      if (wait_cyc > WAIT_LIMIT) begin
        fail_now("fetch response did not arrive");
      end
      wait_cyc++;
      @(posedge clk);
    end
    #DRIVE_DLY;
  endtask

  task automatic fetch_expect(input logic [ADDR_W-1:0] a, input bit exp_miss);
    stim_q.push_back(a);
    run_stream();
    wait_responses();
    assert (last_miss == exp_miss)
      else begin
        $display("MISMATCH at %0t: fetch %h miss=%0d, expected %0d", $time, a, last_miss,
                 exp_miss);
        seq_errors++;
      end
  endtask

  task automatic cacop_op(input cacop_mode_e mode, input logic [ADDR_W-1:0] a);
    int wait_cyc;
    wait_cyc    = 0;
    cacop_valid = 1'b1;
    cacop_mode  = mode;
    cacop_addr  = a;
    @(negedge clk);
    while (!cacop_ready) begin
      if (wait_cyc > WAIT_LIMIT) begin
        fail_now("maintenance request was never accepted");
      end
      wait_cyc++;
      @(negedge clk);
    end
    assert (!cacop_done)
      else begin
        $display("MISMATCH at %0t: done high before accepting op on %h", $time, a);
        seq_errors++;
      end
    @(posedge clk);
    #DRIVE_DLY;
    cacop_valid = 1'b0;
    @(negedge clk);
    assert (cacop_done)
      else begin
        $display("MISMATCH at %0t: done=%0d one cycle after accepting op on %h", $time,
                 cacop_done, a);
        seq_errors++;
      end
    @(negedge clk);
    assert (!cacop_done)
      else begin
        $display("MISMATCH at %0t: done held longer than one cycle", $time);
        seq_errors++;
      end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic start_test();
    test_err0 = cmp_errors + seq_errors;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, cmp_errors + seq_errors - test_err0);
  endtask

  initial begin : abort_watch
    wait (abort_req);
    $display("TEST FAILED");
    $finish;
  end

  // ====================
  // main sequence
  // ====================
  initial begin : main
    int way;
    int reads0;
    int misses0;
    void'($urandom(32'h177394a4));
    rst_n       = 1'b0;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    cacop_valid = 1'b0;
    cacop_mode  = CACOP_INDEX_INV;
    cacop_addr  = '0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    start_test();
    fetch_expect(32'h0000_2010, 1'b1);
    fetch_expect(32'h0000_201c, 1'b0);
    end_test("cold miss then hit in the same line");

    start_test();
    fetch_expect(32'h0000_3050, 1'b1);
    fetch_expect(32'h0000_4050, 1'b1);
    fetch_expect(32'h0000_3050, 1'b0);
    fetch_expect(32'h0000_4050, 1'b0);
    // 4050 hit last, so the third tag lands on the way of 3050
    fetch_expect(32'h0000_5050, 1'b1);
    fetch_expect(32'h0000_4050, 1'b0);
    fetch_expect(32'h0000_3050, 1'b1);
    end_test("two ways per set and replacement");

    start_test();
    reads0  = read_cnt;
    misses0 = model_misses;
    for (int i = 0; i < 64; i++) begin
      stim_q.push_back(32'h0001_0000 | ($urandom_range(3, 0) << 8) |
                       ($urandom_range(3, 0) << 4) | ($urandom_range(3, 0) << 2));
    end
    run_stream();
    wait_responses();
    assert (read_cnt - reads0 == model_misses - misses0)
      else begin
        $display("MISMATCH at %0t: %0d reads, model expects %0d", $time, read_cnt - reads0,
                 model_misses - misses0);
        seq_errors++;
      end
    end_test("random stream with memory stalls");

    start_test();
    fetch_expect(32'h0000_7090, 1'b1);
    fetch_expect(32'h0000_8090, 1'b1);
    way = model_way(32'h0000_8090);
    if (way < 0) begin
      $display("line 8090 is not resident before the index invalidate");
      seq_errors++;
    end
    // way number rides in the low address bits and the tag plays no part
    cacop_op(CACOP_INDEX_INV, 32'h0000_f090 | ADDR_W'(way));
    fetch_expect(32'h0000_7090, 1'b0);
    fetch_expect(32'h0000_8090, 1'b1);
    end_test("index invalidate");

    start_test();
    fetch_expect(32'h0000_90a0, 1'b1);
    cacop_op(CACOP_HIT_INV, 32'h0000_90a0);
    fetch_expect(32'h0000_90a0, 1'b1);
    way = model_way(32'h0000_90a0);
    if (way < 0) begin
      $display("line 90a0 is not resident before the second hit invalidate");
      seq_errors++;
    end
    // absent tag in the same set whose low bits name the resident way
    cacop_op(CACOP_HIT_INV, 32'h0000_a0a0 | ADDR_W'(way));
    fetch_expect(32'h0000_90a4, 1'b0);
    end_test("hit invalidate");

    $display("tests %0d, responses %0d, reads %0d, errors %0d", test_cnt, rsp_cnt, read_cnt,
             cmp_errors + seq_errors);
    if (cmp_errors + seq_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`default_nettype none

module tb_mem_model import icache_pkg::*; (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic [WORD_W-1:0] pattern_i,
  input  wire logic              ar_valid_i,
  input  wire logic [ADDR_W-1:0] ar_addr_i,
  output logic                   ar_ready_o,
  output logic                   r_valid_o,
  output logic [WORD_W-1:0]      r_data_o,
  output logic                   r_last_o
);

  localparam int DRIVE_DLY = 10;

  logic [ADDR_W-1:0] line_addr;
  int                beat;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_last_o   = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && ar_valid_i) begin
        line_addr = ar_addr_i;
        // random delay before the request is taken
        repeat ($urandom_range(2, 0)) @(posedge clk);
        @(posedge clk);
        #DRIVE_DLY;
        ar_ready_o = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        ar_ready_o = 1'b0;
        beat = 0;
        while (beat < LINE_WORDS) begin
          if ($urandom_range(3, 0) == 0) begin
            // gap in the burst
            r_valid_o = 1'b0;
            r_last_o  = 1'b0;
          end else begin
            r_valid_o = 1'b1;
            r_data_o  = (line_addr + ADDR_W'(4 * beat)) ^ pattern_i;
            r_last_o  = (beat == LINE_WORDS - 1);
            beat++;
          end
          @(posedge clk);
          #DRIVE_DLY;
        end
        r_valid_o = 1'b0;
        r_last_o  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire
